//--- src/div_types_pkg.sv
// Widths and vector types shared by every block of the matrix divider; import with div_types_pkg::*

package div_types_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Operand width, dividend and divisor alike
  localparam int DATA_W = 32;

  // Matrix sizes and loop indices
  localparam int IDX_W = 8;

  // Iteration counter holds 0 .. DATA_W
  localparam int STEP_W = $clog2(DATA_W + 1);

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // Dividend, divisor, quotient, remainder
  typedef logic [DATA_W-1:0] data_t;

  // Sizes and i/j indices
  typedef logic [IDX_W-1:0] index_t;

  // Core iteration count
  typedef logic [STEP_W-1:0] step_t;

  ////////////////////////////////////////////////////////////
  // Derived constants
  ////////////////////////////////////////////////////////////

  // Count value seen while the core performs its final step
  localparam step_t LAST_STEP = step_t'(DATA_W - 1);

  // First step is done on the load edge
  localparam step_t FIRST_STEP = step_t'(1);

endpackage

//--- src/div_ctrl_pkg.sv
// FSM encodings and the request/result structs passed between divider blocks; import with div_ctrl_pkg::*

package div_ctrl_pkg;

  import div_types_pkg::*;

  ////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////

  // Sequencer: idle, first element of a row, any other element, division running
  typedef enum logic [1:0] {
    SEQ_IDLE           = 2'd0,
    SEQ_WAIT_ROW_FIRST = 2'd1,
    SEQ_WAIT_ELEM      = 2'd2,
    SEQ_BUSY           = 2'd3
  } seq_state_t;

  // Divider core
  typedef enum logic {
    CORE_IDLE = 1'b0,
    CORE_RUN  = 1'b1
  } core_state_t;

  ////////////////////////////////////////////////////////////
  // Block interfaces
  ////////////////////////////////////////////////////////////

  // One division request, sequencer to core
  typedef struct packed {
    data_t dividend;
    data_t divisor;
    logic  last_in_row;
    logic  last_in_matrix;
  } div_op_t;

  // One finished division, core to result stage
  // Flags ride along unchanged from the request
  typedef struct packed {
    data_t quotient;
    data_t remainder;
    logic  last_in_row;
    logic  last_in_matrix;
  } div_res_t;

endpackage

//--- src/matrix_divider_sequencer.sv
// Decode stage of the matrix divider; walks i/j, captures A/B pairs and issues one division at a time
`timescale 1ns/1ps

module matrix_divider_sequencer
  import div_types_pkg::*, div_ctrl_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    start,
  input  index_t  size_i,
  input  index_t  size_j,
  input  data_t   data_a,
  input  data_t   data_b,
  input  logic    a_i_enable,
  input  logic    a_j_enable,
  input  logic    b_i_enable,
  input  logic    b_j_enable,
  input  logic    done,
  output div_op_t op,
  output logic    op_start
);

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  seq_state_t state;

  // Sizes frozen at start
  index_t size_i_q;
  index_t size_j_q;

  // Position of the element being collected or divided
  index_t index_i;
  index_t index_j;

  // Operand captured flags
  logic a_cap;
  logic b_cap;

  logic accept_a;
  logic accept_b;
  logic take_a;
  logic take_b;
  logic issue;
  logic row_end;
  logic matrix_end;

  ////////////////////////////////////////////////////////////
  // Strobe qualification
  ////////////////////////////////////////////////////////////

  always_comb begin
    // i strobes only for a row's first element, j strobes otherwise
    accept_a = ((state == SEQ_WAIT_ROW_FIRST) && a_i_enable) ||
               ((state == SEQ_WAIT_ELEM) && a_j_enable);
    accept_b = ((state == SEQ_WAIT_ROW_FIRST) && b_i_enable) ||
               ((state == SEQ_WAIT_ELEM) && b_j_enable);
    // First operand seen is kept and later duplicates dropped
    take_a   = accept_a && !a_cap;
    take_b   = accept_b && !b_cap;
    // Both halves in hand
    issue    = ((state == SEQ_WAIT_ROW_FIRST) || (state == SEQ_WAIT_ELEM)) &&
               a_cap && b_cap;
    // Position flags for the pending element
    row_end    = (index_j == size_j_q - index_t'(1));
    matrix_end = row_end && (index_i == size_i_q - index_t'(1));
  end

  ////////////////////////////////////////////////////////////
  // Operand and request registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (take_a) begin
      op.dividend <= data_a;
    end
    if (take_b) begin
      op.divisor <= data_b;
    end
    // Flags fixed when the request leaves
    if (issue) begin
      op.last_in_row    <= row_end;
      op.last_in_matrix <= matrix_end;
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= SEQ_IDLE;
      size_i_q <= '0;
      size_j_q <= '0;
      index_i  <= '0;
      index_j  <= '0;
      a_cap    <= 1'b0;
      b_cap    <= 1'b0;
      op_start <= 1'b0;
    end else begin
      // Single-cycle pulse by default
      op_start <= 1'b0;
      if (take_a) begin
        a_cap <= 1'b1;
      end
      if (take_b) begin
        b_cap <= 1'b1;
      end
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            size_i_q <= size_i;
            size_j_q <= size_j;
            index_i  <= '0;
            index_j  <= '0;
            a_cap    <= 1'b0;
            b_cap    <= 1'b0;
            state    <= SEQ_WAIT_ROW_FIRST;
          end
        end
        SEQ_WAIT_ROW_FIRST, SEQ_WAIT_ELEM: begin
          if (issue) begin
            op_start <= 1'b1;
            a_cap    <= 1'b0;
            b_cap    <= 1'b0;
            state    <= SEQ_BUSY;
          end
        end
        SEQ_BUSY: begin
          // Advance once the core reports back
          if (done) begin
            if (op.last_in_matrix) begin
              state <= SEQ_IDLE;
            end else if (op.last_in_row) begin
              index_i <= index_i + index_t'(1);
              index_j <= '0;
              state   <= SEQ_WAIT_ROW_FIRST;
            end else begin
              index_j <= index_j + index_t'(1);
              state   <= SEQ_WAIT_ELEM;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Core answers only the one request outstanding in BUSY
  a_done_when_busy: assert property (@(posedge CLK) disable iff (RST)
    done |-> state == SEQ_BUSY)
    else $error("done seen with no division outstanding");

endmodule

//--- src/integer_divider_core.sv
// Execute stage; unsigned restoring divider retiring one quotient bit per cycle
`timescale 1ns/1ps

module integer_divider_core
  import div_types_pkg::*, div_ctrl_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     op_start,
  input  div_op_t  op,
  output logic     done,
  output div_res_t res
);

  core_state_t state;
  step_t       step_cnt;

  // Working registers
  data_t divisor_q;
  data_t rem_q;
  data_t quo_q;
  logic  last_row_q;
  logic  last_mat_q;

  // One iteration, inputs muxed between fresh request and running values
  data_t                 step_rem;
  data_t                 step_quo;
  data_t                 step_dvs;
  logic [2*DATA_W-1:0]   step_out;

  logic load;

  ////////////////////////////////////////////////////////////
  // Restoring step
  ////////////////////////////////////////////////////////////

  // Shift in next dividend bit, trial subtract, restore on borrow
  // Zero divisor never borrows: all-ones quotient, remainder = dividend
  function automatic logic [2*DATA_W-1:0] div_step(input data_t rem,
                                                   input data_t quo,
                                                   input data_t dvs);
    logic [DATA_W:0] partial;
    logic [DATA_W:0] diff;
    partial = {rem, quo[DATA_W-1]};
    diff    = partial - {1'b0, dvs};
    if (diff[DATA_W]) begin
      return {partial[DATA_W-1:0], quo[DATA_W-2:0], 1'b0};
    end
    return {diff[DATA_W-1:0], quo[DATA_W-2:0], 1'b1};
  endfunction

  assign load = (state == CORE_IDLE) && op_start;

  always_comb begin
    // First step runs straight off the request
    step_rem = load ? '0 : rem_q;
    step_quo = load ? op.dividend : quo_q;
    step_dvs = load ? op.divisor : divisor_q;
    step_out = div_step(step_rem, step_quo, step_dvs);
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (load) begin
      divisor_q  <= op.divisor;
      last_row_q <= op.last_in_row;
      last_mat_q <= op.last_in_matrix;
    end
    if (load || (state == CORE_RUN)) begin
      {rem_q, quo_q} <= step_out;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= CORE_IDLE;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        CORE_IDLE: begin
          if (op_start) begin
            step_cnt <= FIRST_STEP;
            state    <= CORE_RUN;
          end
        end
        CORE_RUN: begin
          step_cnt <= step_cnt + step_t'(1);
          // Final bit lands this edge; DATA_W cycles after op_start
          if (step_cnt == LAST_STEP) begin
            done  <= 1'b1;
            state <= CORE_IDLE;
          end
        end
        default: state <= CORE_IDLE;
      endcase
    end
  end

  always_comb begin
    res.quotient       = quo_q;
    res.remainder      = rem_q;
    res.last_in_row    = last_row_q;
    res.last_in_matrix = last_mat_q;
  end

  // Requests only accepted when idle
  a_start_in_idle: assert property (@(posedge CLK) disable iff (RST)
    op_start |-> state == CORE_IDLE)
    else $error("op_start while core running");

  // Completion strobe lasts one cycle
  a_done_pulse: assert property (@(posedge CLK) disable iff (RST)
    done |=> !done)
    else $error("done held longer than one cycle");

endmodule

//--- src/divider_result_stage.sv
// Result stage; registers quotient and remainder and raises output strobes and the completion pulse
`timescale 1ns/1ps

module divider_result_stage
  import div_types_pkg::*, div_ctrl_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     done,
  input  div_res_t res,
  output data_t    data_out,
  output data_t    rest_out,
  output logic     data_out_i_enable,
  output logic     data_out_j_enable,
  output logic     ready
);

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out          <= '0;
      rest_out          <= '0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      ready             <= 1'b0;
    end else begin
      // Hold last value between results
      if (done) begin
        data_out <= res.quotient;
        rest_out <= res.remainder;
      end
      // Every element
      data_out_j_enable <= done;
      // Row boundary, except the final row
      data_out_i_enable <= done && res.last_in_row && !res.last_in_matrix;
      // Whole matrix finished
      ready             <= done && res.last_in_matrix;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Row and matrix strobes ride on an element strobe, never together
  a_ready_vs_row: assert property (@(posedge CLK) disable iff (RST)
    (ready || data_out_i_enable) |-> data_out_j_enable && !(ready && data_out_i_enable))
    else $error("ready and data_out_i_enable overlap");

  // Matrix end is followed by a quiet cycle
  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready && !data_out_j_enable)
    else $error("ready not a single isolated pulse");

endmodule

//--- src/matrix_integer_divider.sv
// Top level of the matrix integer divider; elementwise A/B with quotient and remainder, row-major
`timescale 1ns/1ps

module matrix_integer_divider
  import div_types_pkg::*, div_ctrl_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,

  // Control
  input  logic   start,
  output logic   ready,

  // Operand strobes, i = first of row, j = the rest
  input  logic   data_a_i_enable,
  input  logic   data_a_j_enable,
  input  logic   data_b_i_enable,
  input  logic   data_b_j_enable,

  // Result strobes
  output logic   data_out_i_enable,
  output logic   data_out_j_enable,

  // Data
  input  index_t size_i,
  input  index_t size_j,
  input  data_t  data_a,
  input  data_t  data_b,
  output data_t  data_out,
  output data_t  rest_out
);

  ////////////////////////////////////////////////////////////
  // Inter-stage wiring
  ////////////////////////////////////////////////////////////

  div_op_t  op;
  logic     op_start;
  div_res_t res;
  logic     done;

  // Decode
  matrix_divider_sequencer i_sequencer (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .size_i    (size_i),
    .size_j    (size_j),
    .data_a    (data_a),
    .data_b    (data_b),
    .a_i_enable(data_a_i_enable),
    .a_j_enable(data_a_j_enable),
    .b_i_enable(data_b_i_enable),
    .b_j_enable(data_b_j_enable),
    .done      (done),
    .op        (op),
    .op_start  (op_start)
  );

  // Execute
  integer_divider_core i_core (
    .CLK     (CLK),
    .RST     (RST),
    .op_start(op_start),
    .op      (op),
    .done    (done),
    .res     (res)
  );

  // Result
  divider_result_stage i_result (
    .CLK              (CLK),
    .RST              (RST),
    .done             (done),
    .res              (res),
    .data_out         (data_out),
    .rest_out         (rest_out),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .ready            (ready)
  );

endmodule

//--- sim/tb_matrix_integer_divider.sv
// Self-checking testbench for the matrix divider; random matrices in, assertions check each result
`timescale 1ns/1ps

module tb_matrix_integer_divider
  import div_types_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int DRIVE_DLY    = 1;
  localparam int NUM_MATRICES = 12;
  localparam int EXP_DEPTH    = NUM_MATRICES * 16;
  // Strobe edge to output rise, plus one edge until the rise is sampled
  localparam int SEEN_LAT     = DATA_W + 3;
  localparam int WATCHDOG_NS  = NUM_MATRICES * 16 * (DATA_W + 10) * CLK_PERIOD;

  // Expected result plus the operands for the recombination check
  typedef struct packed {
    data_t dividend;
    data_t divisor;
    data_t quotient;
    data_t remainder;
    logic  last_in_row;
    logic  last_in_matrix;
  } expect_t;

  logic   CLK;
  logic   RST;
  logic   start;
  index_t size_i;
  index_t size_j;
  data_t  data_a;
  data_t  data_b;
  logic   data_a_i_enable;
  logic   data_a_j_enable;
  logic   data_b_i_enable;
  logic   data_b_j_enable;
  data_t  data_out;
  data_t  rest_out;
  logic   data_out_i_enable;
  logic   data_out_j_enable;
  logic   ready;

  // Reference model FIFO
  expect_t exp_mem [0:EXP_DEPTH-1];
  expect_t exp_head;
  int      wr_ptr;
  int      rd_ptr;

  // Bookkeeping seen by the assertions
  logic        complete_mark;
  logic        started;
  logic        open_matrix;
  int          exp_count;
  int          j_count;
  int          ready_count;
  logic        zero_seen;
  logic        apart_seen;
  logic        together_seen;
  logic [31:0] lfsr_state;

  matrix_integer_divider i_dut (.*);

  assign exp_head = exp_mem[rd_ptr];

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "run aborted");
  endtask

  // Move to the drive point of the next cycle
  task automatic next_cycle();
    @(posedge CLK);
    #DRIVE_DLY;
  endtask

  // Galois LFSR on x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic set_strobes(input logic row_first, input logic a_on, input logic b_on);
    data_a_i_enable = row_first && a_on;
    data_b_i_enable = row_first && b_on;
    data_a_j_enable = !row_first && a_on;
    data_b_j_enable = !row_first && b_on;
  endtask

  // order 1 = A first, 2 = B first, else both in one cycle
  task automatic send_pair(input logic row_first, input data_t a, input data_t b,
                           input logic [1:0] order, input logic gap);
    data_a = a;
    data_b = b;
    if (order == 2'd1 || order == 2'd2) begin
      apart_seen = 1'b1;
      set_strobes(row_first, order == 2'd1, order == 2'd2);
      next_cycle();
      set_strobes(row_first, 1'b0, 1'b0);
      if (gap) begin
        next_cycle();
      end
      set_strobes(row_first, order == 2'd2, order == 2'd1);
    end else begin
      together_seen = 1'b1;
      set_strobes(row_first, 1'b1, 1'b1);
    end
    // Marks the completing strobe
    complete_mark = 1'b1;
    next_cycle();
    set_strobes(row_first, 1'b0, 1'b0);
    complete_mark = 1'b0;
  endtask

  task automatic run_matrix();
    logic [31:0] r;
    index_t      si;
    index_t      sj;
    data_t       a;
    data_t       b;
    logic [1:0]  order;
    logic        gap;
    expect_t     e;
    rand_bits(2, r);
    si = index_t'(r[1:0]) + index_t'(1);
    rand_bits(2, r);
    sj = index_t'(r[1:0]) + index_t'(1);
    size_i  = si;
    size_j  = sj;
    started = 1'b1;
    start   = 1'b1;
    next_cycle();
    start = 1'b0;
    for (int i = 0; i < int'(si); i++) begin
      for (int j = 0; j < int'(sj); j++) begin
        rand_bits(32, a);
        rand_bits(32, b);
        // Shorter divisors give wider quotients
        rand_bits(5, r);
        b = b >> r[4:0];
        rand_bits(3, r);
        if (r[2:0] == 3'd0) begin
          b = '0;
          zero_seen = 1'b1;
        end
        rand_bits(2, r);
        order = r[1:0];
        rand_bits(1, r);
        gap = r[0];
        // Zero divisor gives all ones and the dividend back
        e.dividend       = a;
        e.divisor        = b;
        e.quotient       = (b == '0) ? '1 : a / b;
        e.remainder      = (b == '0) ? a : a % b;
        e.last_in_row    = (j == int'(sj) - 1);
        e.last_in_matrix = e.last_in_row && (i == int'(si) - 1);
        exp_mem[wr_ptr] = e;
        wr_ptr++;
        send_pair(j == 0, a, b, order, gap);
        while (!data_out_j_enable) begin
          next_cycle();
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (data_out_j_enable) begin
      rd_ptr <= rd_ptr + 1;
    end
    if (start) begin
      j_count   <= 0;
      exp_count <= int'(size_i) * int'(size_j);
    end else if (data_out_j_enable) begin
      j_count <= j_count + 1;
    end
    if (ready) begin
      open_matrix <= 1'b0;
      ready_count <= ready_count + 1;
    end
    // Start of the next matrix may share the edge with the previous ready
    if (start) begin
      open_matrix <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_expected: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable |-> rd_ptr < wr_ptr)
    else abort_run($sformatf("FAIL %0t: result with no operands sent", $time));

  a_quotient: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable |-> data_out == exp_head.quotient && rest_out == exp_head.remainder)
    else abort_run($sformatf("FAIL %0t: got q=%h r=%h, expected q=%h r=%h", $time,
                             data_out, rest_out, exp_head.quotient, exp_head.remainder));

  // q*d + r rebuilds the dividend, and r stays below d
  a_recombine: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable && exp_head.divisor != '0 |->
      64'(data_out) * 64'(exp_head.divisor) + 64'(rest_out) == 64'(exp_head.dividend) &&
      rest_out < exp_head.divisor)
    else abort_run($sformatf("FAIL %0t: q*d+r does not give the dividend", $time));

  a_div_zero: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable && exp_head.divisor == '0 |->
      data_out == '1 && rest_out == exp_head.dividend)
    else abort_run($sformatf("FAIL %0t: wrong result for zero divisor", $time));

  a_row_strobe: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable |->
      data_out_i_enable == (exp_head.last_in_row && !exp_head.last_in_matrix) &&
      ready == exp_head.last_in_matrix)
    else abort_run($sformatf("FAIL %0t: row or matrix strobe misplaced", $time));

  a_strobe_alone: assert property (@(posedge CLK) disable iff (RST)
    (ready || data_out_i_enable) |-> data_out_j_enable)
    else abort_run($sformatf("FAIL %0t: strobe without element strobe", $time));

  a_ready_once: assert property (@(posedge CLK) disable iff (RST)
    ready |-> open_matrix && j_count + 1 == exp_count)
    else abort_run($sformatf("FAIL %0t: ready repeated or element count %0d != %0d",
                             $time, j_count + 1, exp_count));

  a_latency_fwd: assert property (@(posedge CLK) disable iff (RST)
    complete_mark |-> ##SEEN_LAT data_out_j_enable)
    else abort_run($sformatf("FAIL %0t: result strobe missing after latency", $time));

  a_latency_back: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable |-> $past(complete_mark, SEEN_LAT))
    else abort_run($sformatf("FAIL %0t: result strobe at wrong latency", $time));

  // Quiet outputs between reset and the first start
  a_quiet: assert property (@(posedge CLK) disable iff (RST)
    !started |-> !ready && !data_out_i_enable && !data_out_j_enable &&
      data_out == '0 && rest_out == '0)
    else abort_run($sformatf("FAIL %0t: outputs active before first start", $time));

  ////////////////////////////////////////////////////////////
  // Stimulus and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    #WATCHDOG_NS;
    abort_run($sformatf("Run timed out after %0d ns", WATCHDOG_NS));
  end

  initial begin
    RST           = 1'b1;
    start         = 1'b0;
    size_i        = '0;
    size_j        = '0;
    data_a        = '0;
    data_b        = '0;
    set_strobes(1'b0, 1'b0, 1'b0);
    complete_mark = 1'b0;
    started       = 1'b0;
    open_matrix   = 1'b0;
    exp_count     = 0;
    j_count       = 0;
    ready_count   = 0;
    wr_ptr        = 0;
    rd_ptr        = 0;
    zero_seen     = 1'b0;
    apart_seen    = 1'b0;
    together_seen = 1'b0;
    lfsr_state    = 32'h1f0f;
    repeat (3) @(posedge CLK);
    #DRIVE_DLY;
    RST = 1'b0;
    repeat (5) next_cycle();
    for (int m = 0; m < NUM_MATRICES; m++) begin
      run_matrix();
    end
    // Let the last strobes be sampled
    repeat (4) next_cycle();
    if (ready_count != NUM_MATRICES) begin
      abort_run($sformatf("FAIL %0t: %0d ready pulses for %0d matrices", $time,
                          ready_count, NUM_MATRICES));
    end else if (!zero_seen || !apart_seen || !together_seen) begin
      abort_run("Stimulus never produced a zero divisor or both strobe orders");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

//--- compile.f
src/div_types_pkg.sv
src/div_ctrl_pkg.sv
src/matrix_divider_sequencer.sv
src/integer_divider_core.sv
src/divider_result_stage.sv
src/matrix_integer_divider.sv
sim/tb_matrix_integer_divider.sv

//--- Bender.yml
package:
  name: matrix_integer_divider

sources:
  # Packages first, types before control
  - src/div_types_pkg.sv
  - src/div_ctrl_pkg.sv
  # Design
  - src/matrix_divider_sequencer.sv
  - src/integer_divider_core.sv
  - src/divider_result_stage.sv
  - src/matrix_integer_divider.sv
  # Simulation only
  - target: test
    files:
      - sim/tb_matrix_integer_divider.sv
